// File: logic/accumulate_stage.sv
module accumulate_stage
    import lenet_mac_pkg::*;
#(
    parameter int ACC_W = acc_w_c,
    parameter int ROW_W = row_w_c
) (
    input  logic       clk,
    input  logic       reset,
    input  row_sum_t   row,
    output win_total_t total
);

    logic [ACC_W-1:0] acc_q;
    logic [ACC_W-1:0] acc_base;
    logic [ACC_W:0]   acc_next;

    if (ACC_W != acc_w_c || ROW_W > ACC_W) begin : g_width_check
        $error("accumulate_stage: ACC_W must equal acc_w_c and hold a row sum");
    end

    // a first row restarts the window, whatever was left over before.
    always_comb begin
        acc_base = row.first ? '0 : acc_q;
        acc_next = {1'b0, acc_base} + {{(ACC_W + 1 - ROW_W){1'b0}}, row.sum};
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // running total

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_q       <= '0;
            total.valid <= 1'b0;
        end else begin
            if (row.valid) begin
                acc_q <= acc_next[ACC_W-1:0];
            end
            total.valid <= row.valid & row.last;
        end
    end

    // the total includes the closing row itself.
    always_ff @(posedge clk) begin
        if (row.valid && row.last) begin
            total.total <= acc_next[ACC_W-1:0];
        end
    end

    a_no_overflow : assert property (
        @(posedge clk) disable iff (reset)
        row.valid |-> !acc_next[ACC_W]
    ) else $error("accumulate_stage: window total overflowed the accumulator");

endmodule

// File: logic/activation_stage.sv
module activation_stage
    import lenet_mac_pkg::*;
#(
    parameter int ACC_W = acc_w_c,
    parameter int SHIFT = 6
) (
    input  logic                clk,
    input  logic                reset,
    input  win_total_t          total,
    output logic                out_valid,
    output logic [data_w_c-1:0] out_act
);

    logic [ACC_W-1:0] shifted;
    logic             saturate;

    // the shift rescales the window total back to activation range.
    assign shifted  = total.total >> SHIFT;
    assign saturate = |shifted[ACC_W-1:data_w_c];

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= total.valid;
        end
    end

    // anything past 8 bits clips to full scale.
    always_ff @(posedge clk) begin
        if (total.valid) begin
            if (saturate) begin
                out_act <= '1;
            end else begin
                out_act <= shifted[data_w_c-1:0];
            end
        end
    end

endmodule

// File: logic/adder_tree_stage.sv
module adder_tree_stage
    import lenet_mac_pkg::*;
#(
    parameter int LANES = lanes_c,
    parameter int ROW_W = row_w_c
) (
    input  logic       clk,
    input  logic       reset,
    input  prod_beat_t prod,
    output row_sum_t   row
);

    // heap layout, leaves sit at LANES-1 and up, node i adds 2i+1 and 2i+2.
    logic [ROW_W-1:0] node [2*LANES-1];

    if (ROW_W != row_w_c) begin : g_width_check
        $error("adder_tree_stage: ROW_W does not match the row sum struct");
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            node[LANES-1+i] = ROW_W'(prod.product[i]);
        end
        for (int i = LANES - 2; i >= 0; i--) begin
            node[i] = node[2*i+1] + node[2*i+2];
        end
    end

    always_ff @(posedge clk) begin
        row.sum <= node[0];
        if (reset) begin
            row.valid <= 1'b0;
            row.first <= 1'b0;
            row.last  <= 1'b0;
        end else begin
            row.valid <= prod.valid;
            row.first <= prod.first;
            row.last  <= prod.last;
        end
    end

endmodule

// File: logic/approx_mult_8x8.sv
module approx_mult_8x8 (
    input  logic [7:0]  x,
    input  logic [7:0]  y,
    output logic [15:0] z
);

    logic [7:0]  pp [8];
    logic [12:0] sp_a;
    logic [12:0] sp_b;
    logic [12:0] sp_c;
    logic [12:0] sp_d;
    logic [12:0] sp_e;

    // row i holds y gated by bit i of x.
    for (genvar i = 0; i < 8; i++) begin : g_pp
        assign pp[i] = y & {8{x[i]}};
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // sparse compression of the lower rows

    // only a fixed handful of neighbouring bits from rows zero to five survive.
    // Each is folded into one of five 13-bit vectors.
    always_comb begin
        sp_a = '0;
        sp_b = '0;
        sp_c = '0;
        sp_d = '0;
        sp_e = '0;

        sp_a[1]  = pp[0][1] ^ pp[1][0];
        sp_a[3]  = pp[2][1] ^ pp[3][0];
        sp_a[4]  = pp[4][0];
        sp_a[5]  = pp[2][3] & pp[3][2];
        sp_a[7]  = pp[0][6] | pp[1][5];
        sp_a[8]  = pp[2][5] | pp[3][4];
        sp_a[9]  = pp[2][7] & pp[3][6];
        sp_a[10] = pp[3][7];
        sp_a[11] = pp[4][6] & pp[5][5];
        sp_a[12] = pp[5][7];

        sp_b[7]  = pp[0][7] ^ pp[1][6];
        sp_b[8]  = pp[2][6] | pp[3][5];
        sp_b[9]  = pp[2][7] | pp[3][6];
        sp_b[10] = pp[4][5] & pp[5][4];
        sp_b[11] = pp[4][7] & pp[5][6];

        sp_c[7]  = pp[2][4] | pp[3][3];
        sp_c[8]  = pp[4][3] | pp[5][2];
        sp_c[9]  = pp[4][5] ^ pp[5][4];
        sp_c[10] = pp[4][6] ^ pp[5][5];
        sp_c[11] = pp[4][7] | pp[5][6];

        sp_d[7]  = pp[4][3] & pp[5][2];
        sp_d[8]  = pp[4][4] & pp[5][3];

        sp_e[8]  = pp[4][4] ^ pp[5][3];
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // final sum

    // rows six and seven go in exactly. The sum wraps at 16 bits.
    assign z = {2'b00, pp[6], 6'b0}
             + {1'b0, pp[7], 7'b0}
             + {3'b000, sp_a}
             + {3'b000, sp_b}
             + {3'b000, sp_c}
             + {3'b000, sp_d}
             + {3'b000, sp_e};

endmodule

// File: logic/conv_mac_pipe.sv
module conv_mac_pipe
    import lenet_mac_pkg::*;
#(
    parameter int LANES = lanes_c,
    parameter int ACC_W = acc_w_c,
    parameter int SHIFT = 6
) (
    input  logic                clk,
    input  logic                reset,
    input  mac_beat_t           in_beat,
    output logic                out_valid,
    output logic [data_w_c-1:0] out_act
);

    // a row sum needs one extra bit per level of the lane tree.
    localparam int ROW_W = prod_w_c + $clog2(LANES);

    prod_beat_t prod;
    row_sum_t   row;
    win_total_t total;

    // ~~~~~~~~~~~~~~~~~~~~
    // four stages, one cycle each

    product_stage #(
        .LANES (LANES)
    ) i_product_stage (
        .clk     (clk),
        .reset   (reset),
        .in_beat (in_beat),
        .prod    (prod)
    );

    adder_tree_stage #(
        .LANES (LANES),
        .ROW_W (ROW_W)
    ) i_adder_tree_stage (
        .clk   (clk),
        .reset (reset),
        .prod  (prod),
        .row   (row)
    );

    accumulate_stage #(
        .ACC_W (ACC_W),
        .ROW_W (ROW_W)
    ) i_accumulate_stage (
        .clk   (clk),
        .reset (reset),
        .row   (row),
        .total (total)
    );

    activation_stage #(
        .ACC_W (ACC_W),
        .SHIFT (SHIFT)
    ) i_activation_stage (
        .clk       (clk),
        .reset     (reset),
        .total     (total),
        .out_valid (out_valid),
        .out_act   (out_act)
    );

endmodule

// File: logic/lenet_mac_pkg.sv
package lenet_mac_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // widths
    localparam int lanes_c  = 4;
    localparam int data_w_c = 8;
    localparam int prod_w_c = 2 * data_w_c;

    // one row sum has room for the carries of the lane adder tree.
    localparam int row_w_c  = prod_w_c + $clog2(lanes_c);
    localparam int acc_w_c  = 24;

    // ~~~~~~~~~~~~~~~~~~~~
    // stage payloads

    // one kernel row of activations and weights.
    typedef struct packed {
        logic                             valid;
        logic                             first;
        logic                             last;
        logic [lanes_c-1:0][data_w_c-1:0] act;
        logic [lanes_c-1:0][data_w_c-1:0] wgt;
    } mac_beat_t;

    typedef struct packed {
        logic                             valid;
        logic                             first;
        logic                             last;
        logic [lanes_c-1:0][prod_w_c-1:0] product;
    } prod_beat_t;

    typedef struct packed {
        logic               valid;
        logic               first;
        logic               last;
        logic [row_w_c-1:0] sum;
    } row_sum_t;

    // the window total carries no frame flags, it only exists on a last row.
    typedef struct packed {
        logic               valid;
        logic [acc_w_c-1:0] total;
    } win_total_t;

endpackage

// File: logic/product_stage.sv
module product_stage
    import lenet_mac_pkg::*;
#(
    parameter int LANES = lanes_c
) (
    input  logic       clk,
    input  logic       reset,
    input  mac_beat_t  in_beat,
    output prod_beat_t prod
);

    logic [LANES-1:0][prod_w_c-1:0] lane_prod;

    // the beat structs are sized by the package lane count.
    if (LANES != lanes_c) begin : g_lanes_check
        $error("product_stage: LANES must equal lanes_c");
    end

    for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
        approx_mult_8x8 i_mult (
            .x (in_beat.act[lane]),
            .y (in_beat.wgt[lane]),
            .z (lane_prod[lane])
        );
    end

    always_ff @(posedge clk) begin
        prod.product <= lane_prod;
        if (reset) begin
            prod.valid <= 1'b0;
            prod.first <= 1'b0;
            prod.last  <= 1'b0;
        end else begin
            prod.valid <= in_beat.valid;
            prod.first <= in_beat.first;
            prod.last  <= in_beat.last;
        end
    end

    // frame flags only ride on real beats, so the accumulator never sees a
    // window opened or closed by a bubble.
    a_flags_need_valid : assert property (
        @(posedge clk) disable iff (reset)
        !in_beat.valid |-> !(in_beat.first || in_beat.last)
    ) else $error("product_stage: first or last set on a beat with valid low");

endmodule

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module tb_conv_mac_pipe; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_conv_mac_pipe > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi

echo "pass message not found in sim.log"
exit 1

// File: include/approx_mult_model.svh
`ifndef APPROX_MULT_MODEL_SVH
`define APPROX_MULT_MODEL_SVH

// reference model of the approximate 8x8 product.
// Rows six and seven are exact, the lower rows contribute only a sparse set
// of combined bits, each weighted by its column.
function automatic logic [15:0] approx_mult_model(
    input logic [7:0] x,
    input logic [7:0] y
);
    logic [7:0]  pp [8];
    logic [15:0] acc;

    for (int i = 0; i < 8; i++) begin
        pp[i] = y & {8{x[i]}};
    end

    acc = 16'(pp[6]) << 6;
    acc += 16'(pp[7]) << 7;

    acc += 16'(pp[0][1] ^ pp[1][0]) << 1;
    acc += 16'(pp[2][1] ^ pp[3][0]) << 3;
    acc += 16'(pp[4][0]) << 4;
    acc += 16'(pp[2][3] & pp[3][2]) << 5;
    acc += 16'(pp[0][6] | pp[1][5]) << 7;
    acc += 16'(pp[2][5] | pp[3][4]) << 8;
    acc += 16'(pp[2][7] & pp[3][6]) << 9;
    acc += 16'(pp[3][7]) << 10;
    acc += 16'(pp[4][6] & pp[5][5]) << 11;
    acc += 16'(pp[5][7]) << 12;

    acc += 16'(pp[0][7] ^ pp[1][6]) << 7;
    acc += 16'(pp[2][6] | pp[3][5]) << 8;
    acc += 16'(pp[2][7] | pp[3][6]) << 9;
    acc += 16'(pp[4][5] & pp[5][4]) << 10;
    acc += 16'(pp[4][7] & pp[5][6]) << 11;

    acc += 16'(pp[2][4] | pp[3][3]) << 7;
    acc += 16'(pp[4][3] | pp[5][2]) << 8;
    acc += 16'(pp[4][5] ^ pp[5][4]) << 9;
    acc += 16'(pp[4][6] ^ pp[5][5]) << 10;
    acc += 16'(pp[4][7] | pp[5][6]) << 11;

    acc += 16'(pp[4][3] & pp[5][2]) << 7;
    acc += 16'(pp[4][4] & pp[5][3]) << 8;
    acc += 16'(pp[4][4] ^ pp[5][3]) << 8;

    return acc;
endfunction

`endif

// File: testbench/tb_conv_mac_pipe.sv
module tb_conv_mac_pipe
    import lenet_mac_pkg::*;
();

    localparam int shift_c    = 6;
    localparam int n_upper    = 16;
    localparam int n_single   = 40;
    localparam int n_zero     = 8;
    localparam int n_windows  = 20;
    localparam int n_bubbled  = 10;
    localparam int n_saturate = 6;
    localparam int gap_c      = 8;

    // worst case beat count of the whole run including reset and gaps.
    localparam int run_beats = 10 + n_upper + n_single + n_zero + 5 * n_windows
                             + 9 * n_bubbled + 4 * n_saturate + 7 * gap_c + 20;

    logic        clk = 1'b0;
    logic        reset;
    mac_beat_t   in_beat;
    logic        out_valid;
    logic [7:0]  out_act;

    logic [15:0] lfsr = 16'd16;
    logic [23:0] window_sum;
    int          cycle_cnt = 0;
    int          due_q [$];
    logic [7:0]  act_q [$];
    int          head_idx = 0;
    logic        pending = 1'b0;
    int          head_due = 0;
    logic [7:0]  head_act = '0;

    int          value_errs = 0;
    int          missing_errs = 0;
    int          unexpected_errs = 0;
    int          reset_errs = 0;

    `include "approx_mult_model.svh"

    conv_mac_pipe #(
        .SHIFT (shift_c)
    ) i_conv_mac_pipe (
        .clk       (clk),
        .reset     (reset),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_act   (out_act)
    );

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // scoreboard

    // the head entry moves on once its due cycle has gone by.
    always @(posedge clk) begin
        int idx;
        idx = head_idx;
        if (idx < due_q.size() && cycle_cnt == due_q[idx]) begin
            idx++;
        end
        head_idx <= idx;
        pending  <= idx < due_q.size();
        if (idx < due_q.size()) begin
            head_due <= due_q[idx];
            head_act <= act_q[idx];
        end
        cycle_cnt <= cycle_cnt + 1;
    end

    a_reset_quiet : assert property (
        @(posedge clk) reset |=> !out_valid
    ) else begin
        reset_errs++;
        $display("out_valid was not cleared by reset at time %0t", $time);
    end

    a_no_unexpected : assert property (
        @(posedge clk) out_valid |-> (pending && cycle_cnt == head_due)
    ) else begin
        unexpected_errs++;
        $display("out_valid pulsed at time %0t with no window due", $time);
    end

    a_no_missing : assert property (
        @(posedge clk) (pending && cycle_cnt == head_due) |-> out_valid
    ) else begin
        missing_errs++;
        $display("out_valid did not pulse at time %0t for a closed window", $time);
    end

    a_value : assert property (
        @(posedge clk) (out_valid && pending && cycle_cnt == head_due) |-> out_act == head_act
    ) else begin
        value_errs++;
        $display("Mismatch at time %0t: out_act is %0d, expected %0d",
                 $time, $sampled(out_act), $sampled(head_act));
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[6:0], lfsr[0]};
        end
        return val;
    endfunction

    // kind 1 keeps bits 6 and 7 only, kind 2 is large, kind 4 has a random width.
    function automatic logic [7:0] rand_operand(input int kind);
        case (kind)
            1: return rand_bits(2) << 6;
            2: return 8'hc0 | rand_bits(6);
            3: return 8'h00;
            4: return rand_bits(1 + int'(rand_bits(3)));
            default: return rand_bits(8);
        endcase
    endfunction

    // window total rescaled by the shift and clipped to full scale.
    function automatic logic [7:0] scale_total(input logic [23:0] total);
        logic [23:0] shifted;
        shifted = total >> shift_c;
        if (shifted > 24'd255) begin
            return 8'hff;
        end
        return shifted[7:0];
    endfunction

    task automatic fill_operands(
        input  int                               act_kind,
        input  int                               wgt_kind,
        output logic [lanes_c-1:0][data_w_c-1:0] acts,
        output logic [lanes_c-1:0][data_w_c-1:0] wgts
    );
        for (int l = 0; l < lanes_c; l++) begin
            acts[l] = rand_operand(act_kind);
            wgts[l] = rand_operand(wgt_kind);
        end
    endtask

    task automatic drive_beat(
        input logic                             valid,
        input logic                             first,
        input logic                             last,
        input logic [lanes_c-1:0][data_w_c-1:0] acts,
        input logic [lanes_c-1:0][data_w_c-1:0] wgts
    );
        @(negedge clk);
        in_beat.valid = valid;
        in_beat.first = first;
        in_beat.last  = last;
        in_beat.act   = acts;
        in_beat.wgt   = wgts;
    endtask

    task automatic send_row(
        input logic [lanes_c-1:0][data_w_c-1:0] acts,
        input logic [lanes_c-1:0][data_w_c-1:0] wgts,
        input logic                             first,
        input logic                             last,
        input logic                             use_exact
    );
        logic [17:0] row_val;
        logic [15:0] prod;
        row_val = '0;
        for (int l = 0; l < lanes_c; l++) begin
            if (use_exact) begin
                prod = 16'(acts[l]) * 16'(wgts[l]);
            end else begin
                prod = approx_mult_model(acts[l], wgts[l]);
            end
            row_val = row_val + 18'(prod);
        end
        window_sum = (first ? 24'd0 : window_sum) + 24'(row_val);
        drive_beat(1'b1, first, last, acts, wgts);
        if (last) begin
            due_q.push_back(cycle_cnt + 4);
            act_q.push_back(scale_total(window_sum));
        end
    endtask

    task automatic send_bubbles(input int count);
        logic [lanes_c-1:0][data_w_c-1:0] acts;
        logic [lanes_c-1:0][data_w_c-1:0] wgts;
        for (int n = 0; n < count; n++) begin
            fill_operands(0, 0, acts, wgts);
            drive_beat(1'b0, 1'b0, 1'b0, acts, wgts);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // test sequences

    task automatic single_rows(input int count, input int act_kind, input int wgt_kind,
                               input logic use_exact);
        logic [lanes_c-1:0][data_w_c-1:0] acts;
        logic [lanes_c-1:0][data_w_c-1:0] wgts;
        for (int n = 0; n < count; n++) begin
            fill_operands(act_kind, wgt_kind, acts, wgts);
            send_row(acts, wgts, 1'b1, 1'b1, use_exact);
        end
    endtask

    task automatic multi_row_windows(input int count, input int kind, input int min_rows);
        logic [lanes_c-1:0][data_w_c-1:0] acts;
        logic [lanes_c-1:0][data_w_c-1:0] wgts;
        int rows;
        for (int n = 0; n < count; n++) begin
            rows = (kind == 2) ? min_rows : min_rows + int'(rand_bits(2));
            for (int r = 0; r < rows; r++) begin
                fill_operands(kind, kind == 2 ? 2 : 4, acts, wgts);
                send_row(acts, wgts, r == 0, r == rows - 1, 1'b0);
            end
        end
    endtask

    // each window follows a partial one that was opened and never closed.
    task automatic windows_with_bubbles(input int count);
        logic [lanes_c-1:0][data_w_c-1:0] acts;
        logic [lanes_c-1:0][data_w_c-1:0] wgts;
        for (int n = 0; n < count; n++) begin
            fill_operands(0, 0, acts, wgts);
            send_row(acts, wgts, 1'b1, 1'b0, 1'b0);
            send_bubbles(int'(rand_bits(1)));
            for (int r = 0; r < 3; r++) begin
                fill_operands(0, 4, acts, wgts);
                send_row(acts, wgts, r == 0, r == 2, 1'b0);
                if (r != 2) begin
                    send_bubbles(1 + int'(rand_bits(1)));
                end
            end
        end
    endtask

    initial begin
        int total_errs;
        in_beat    = '0;
        reset      = 1'b1;
        window_sum = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        send_bubbles(gap_c);

        single_rows(n_upper, 1, 0, 1'b1);
        send_bubbles(gap_c);
        single_rows(n_single, 0, 4, 1'b0);
        single_rows(n_zero / 2, 3, 0, 1'b0);
        single_rows(n_zero / 2, 0, 3, 1'b0);
        send_bubbles(gap_c);
        multi_row_windows(n_windows, 4, 2);
        send_bubbles(gap_c);
        windows_with_bubbles(n_bubbled);
        send_bubbles(gap_c);
        multi_row_windows(n_saturate, 2, 4);
        send_bubbles(gap_c);

        while (head_idx < due_q.size()) begin
            @(negedge clk);
        end
        send_bubbles(gap_c);

        total_errs = value_errs + missing_errs + unexpected_errs + reset_errs;
        $display("errors: value %0d, missing %0d, unexpected %0d, during reset %0d",
                 value_errs, missing_errs, unexpected_errs, reset_errs);
        if (total_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(run_beats * 20 + 200);
        $display("timeout: the run did not finish within %0d time units",
                 run_beats * 20 + 200);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
logic/lenet_mac_pkg.sv
logic/approx_mult_8x8.sv
logic/product_stage.sv
logic/adder_tree_stage.sv
logic/accumulate_stage.sv
logic/activation_stage.sv
logic/conv_mac_pipe.sv
testbench/tb_conv_mac_pipe.sv
